/* Bender.yml */
package:
  name: ddr3_model

sources:
  # packages first, then leaf modules, then the top level
  - rtl/ddr3_geom_pkg.sv
  - rtl/ddr3_proto_pkg.sv
  - rtl/ddr3_cmd_decode.sv
  - rtl/ddr3_latency_line.sv
  - rtl/ddr3_ddr_capture.sv
  - rtl/ddr3_write_burst.sv
  - rtl/ddr3_read_burst.sv
  - rtl/ddr3_byte_ram.sv
  - rtl/ddr3_model_top.sv
  - target: test
    files:
      - testbench/tb_ddr3_model.sv

/* rtl/ddr3_byte_ram.sv */
`default_nettype none

module ddr3_byte_ram (
	input wire logic clk,
	input wire logic we,
	input wire ddr3_geom_pkg::ram_addr_t wr_addr,
	input wire ddr3_geom_pkg::ram_addr_t rd_addr,
	input wire ddr3_geom_pkg::byte_t wr_data,
	output ddr3_geom_pkg::byte_t rd_data
);

	// one byte per {bank, row, group, pair}
	ddr3_geom_pkg::byte_t mem [2**$bits(ddr3_geom_pkg::ram_addr_t)];

	always_ff @(posedge clk)
	begin
		if (we)
			mem[wr_addr] <= wr_data;
	end

	// registered read, independent of the write port
	always_ff @(posedge clk)
	begin
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* rtl/ddr3_cmd_decode.sv */
`default_nettype none

module ddr3_cmd_decode (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic cs_n,
	input wire logic ras_n,
	input wire logic cas_n,
	input wire logic we_n,
	input wire ddr3_geom_pkg::bank_t ba,
	input wire ddr3_geom_pkg::pin_addr_t a,
	output logic rd_valid,
	output logic wr_valid,
	output ddr3_geom_pkg::burst_addr_t cmd_addr
);

	ddr3_proto_pkg::cmd_e cmd;
	ddr3_geom_pkg::row_t open_row [2**ddr3_geom_pkg::bank_w];
	ddr3_geom_pkg::row_t row_pin;
	logic [ddr3_geom_pkg::group_w-1:0] col_group;

	// pin code at this edge
	assign cmd = ddr3_proto_pkg::cmd_e'({cs_n, ras_n, cas_n, we_n});
	// low pins only, upper row bits ignored
	assign row_pin = a[ddr3_geom_pkg::row_w-1:0];
	// bits below the burst length select the beat, not the group
	assign col_group = a[ddr3_geom_pkg::col_w-1:$clog2(ddr3_proto_pkg::burst_beats)];

	// open row per bank and the column command pulses
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			rd_valid <= 1'b0;
			wr_valid <= 1'b0;
			for (int i = 0; i < 2**ddr3_geom_pkg::bank_w; i++)
				open_row[i] <= '0;
		end
		else
		begin
			rd_valid <= 1'b0;
			wr_valid <= 1'b0;
			case (cmd)
				ddr3_proto_pkg::cmd_activate: open_row[ba] <= row_pin;
				ddr3_proto_pkg::cmd_read: rd_valid <= 1'b1;
				ddr3_proto_pkg::cmd_write: wr_valid <= 1'b1;
				ddr3_proto_pkg::cmd_nop: ;
				// other codes are ignored
				default: ;
			endcase
		end
	end

	// burst address, taken from the bank's open row
	always_ff @(posedge clk)
	begin
		if (cmd == ddr3_proto_pkg::cmd_read || cmd == ddr3_proto_pkg::cmd_write)
			cmd_addr <= {ba, open_row[ba], col_group};
	end

	// both burst sequencers rely on this spacing
	a_cmd_gap: assert property (@(posedge clk) disable iff (!reset_n)
		(rd_valid || wr_valid) |=>
			(!(rd_valid || wr_valid)) [*ddr3_proto_pkg::min_cmd_gap-1]);

endmodule

`default_nettype wire

/* rtl/ddr3_ddr_capture.sv */
`default_nettype none

module ddr3_ddr_capture (
	input wire logic clk,
	input wire logic reset_n,
	input wire ddr3_geom_pkg::byte_t dq_in,
	input wire logic dm,
	output ddr3_geom_pkg::byte_t even_byte,
	output ddr3_geom_pkg::byte_t odd_byte,
	output logic even_mask,
	output logic odd_mask
);

	ddr3_geom_pkg::byte_t rise_byte;
	ddr3_geom_pkg::byte_t fall_byte;
	logic rise_mask;
	logic fall_mask;

	// masks come out of reset high, nothing gets written
	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			rise_mask <= 1'b1;
			even_mask <= 1'b1;
			odd_mask <= 1'b1;
		end
		else
		begin
			rise_mask <= dm;
			// fall sample is from the half cycle after rise_mask
			even_mask <= rise_mask;
			odd_mask <= fall_mask;
		end
	end

	// odd beat, middle of the cycle
	always_ff @(negedge clk)
	begin
		if (!reset_n)
			fall_mask <= 1'b1;
		else
			fall_mask <= dm;
	end

	always_ff @(negedge clk)
	begin
		fall_byte <= dq_in;
	end

	// even beat, then both realigned to the rising edge
	always_ff @(posedge clk)
	begin
		rise_byte <= dq_in;
		even_byte <= rise_byte;
		odd_byte <= fall_byte;
	end

endmodule

`default_nettype wire

/* rtl/ddr3_geom_pkg.sv */
`default_nettype none

package ddr3_geom_pkg;

	// storage geometry, much smaller than a real part
	localparam int bank_w = 3;
	localparam int row_w = 6;
	localparam int col_w = 7;
	localparam int pin_addr_w = 13;
	// column bits left once the BL8 offset is dropped
	localparam int group_w = col_w - 3;
	// beat pair index inside one burst
	localparam int pair_w = 2;

	typedef logic [bank_w-1:0] bank_t;
	typedef logic [row_w-1:0] row_t;
	typedef logic [col_w-1:0] col_t;
	typedef logic [pin_addr_w-1:0] pin_addr_t;
	typedef logic [7:0] byte_t;

	// {bank, open row, column group}
	typedef logic [bank_w+row_w+group_w-1:0] burst_addr_t;
	// {burst address, pair}, one byte per entry in each ram
	typedef logic [bank_w+row_w+group_w+pair_w-1:0] ram_addr_t;

endpackage

`default_nettype wire

/* rtl/ddr3_latency_line.sv */
`default_nettype none

module ddr3_latency_line #(
	parameter int depth = 1
) (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic in_valid,
	input wire ddr3_geom_pkg::burst_addr_t in_addr,
	output logic out_valid,
	output ddr3_geom_pkg::burst_addr_t out_addr
);

	logic [depth-1:0] valid_q;
	ddr3_geom_pkg::burst_addr_t addr_q [depth];

	// one stage per cycle of latency
	always_ff @(posedge clk)
	begin
		if (!reset_n)
			valid_q <= '0;
		else
		begin
			valid_q[0] <= in_valid;
			for (int i = 1; i < depth; i++)
				valid_q[i] <= valid_q[i-1];
		end
	end

	// address rides along with its valid bit
	always_ff @(posedge clk)
	begin
		addr_q[0] <= in_addr;
		for (int i = 1; i < depth; i++)
			addr_q[i] <= addr_q[i-1];
	end

	assign out_valid = valid_q[depth-1];
	assign out_addr = addr_q[depth-1];

endmodule

`default_nettype wire

/* rtl/ddr3_model_top.sv */
`default_nettype none

module ddr3_model_top (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic cs_n,
	input wire logic ras_n,
	input wire logic cas_n,
	input wire logic we_n,
	input wire ddr3_geom_pkg::bank_t ba,
	input wire ddr3_geom_pkg::pin_addr_t a,
	input wire ddr3_geom_pkg::byte_t dq_in,
	input wire logic dm,
	output ddr3_geom_pkg::byte_t dq_out,
	output logic dq_oe,
	output logic dqs_en
);

	// command path
	logic rd_valid;
	logic wr_valid;
	ddr3_geom_pkg::burst_addr_t cmd_addr;
	logic rd_start;
	logic wr_start;
	ddr3_geom_pkg::burst_addr_t rd_start_addr;
	ddr3_geom_pkg::burst_addr_t wr_start_addr;

	// write data path
	ddr3_geom_pkg::byte_t even_byte;
	ddr3_geom_pkg::byte_t odd_byte;
	logic even_mask;
	logic odd_mask;
	ddr3_geom_pkg::ram_addr_t wr_addr;
	logic even_we;
	logic odd_we;

	// read data path
	ddr3_geom_pkg::ram_addr_t rd_addr;
	ddr3_geom_pkg::byte_t ram_even_q;
	ddr3_geom_pkg::byte_t ram_odd_q;

	ddr3_cmd_decode u_cmd_decode (
		.clk      (clk),
		.reset_n  (reset_n),
		.cs_n     (cs_n),
		.ras_n    (ras_n),
		.cas_n    (cas_n),
		.we_n     (we_n),
		.ba       (ba),
		.a        (a),
		.rd_valid (rd_valid),
		.wr_valid (wr_valid),
		.cmd_addr (cmd_addr)
	);

	// RL minus the ram read register
	ddr3_latency_line #(
		.depth (ddr3_proto_pkg::read_latency - 1)
	) u_rd_line (
		.clk       (clk),
		.reset_n   (reset_n),
		.in_valid  (rd_valid),
		.in_addr   (cmd_addr),
		.out_valid (rd_start),
		.out_addr  (rd_start_addr)
	);

	// WL plus the capture register
	ddr3_latency_line #(
		.depth (ddr3_proto_pkg::write_latency + ddr3_proto_pkg::capture_delay)
	) u_wr_line (
		.clk       (clk),
		.reset_n   (reset_n),
		.in_valid  (wr_valid),
		.in_addr   (cmd_addr),
		.out_valid (wr_start),
		.out_addr  (wr_start_addr)
	);

	ddr3_ddr_capture u_capture (
		.clk       (clk),
		.reset_n   (reset_n),
		.dq_in     (dq_in),
		.dm        (dm),
		.even_byte (even_byte),
		.odd_byte  (odd_byte),
		.even_mask (even_mask),
		.odd_mask  (odd_mask)
	);

	ddr3_write_burst u_write_burst (
		.clk        (clk),
		.reset_n    (reset_n),
		.start      (wr_start),
		.start_addr (wr_start_addr),
		.even_mask  (even_mask),
		.odd_mask   (odd_mask),
		.wr_addr    (wr_addr),
		.even_we    (even_we),
		.odd_we     (odd_we)
	);

	ddr3_read_burst u_read_burst (
		.clk        (clk),
		.reset_n    (reset_n),
		.start      (rd_start),
		.start_addr (rd_start_addr),
		.even_byte  (ram_even_q),
		.odd_byte   (ram_odd_q),
		.rd_addr    (rd_addr),
		.dq_out     (dq_out),
		.dq_oe      (dq_oe),
		.dqs_en     (dqs_en)
	);

	// beats 0, 2, 4, 6
	ddr3_byte_ram u_ram_even (
		.clk     (clk),
		.we      (even_we),
		.wr_addr (wr_addr),
		.rd_addr (rd_addr),
		.wr_data (even_byte),
		.rd_data (ram_even_q)
	);

	// beats 1, 3, 5, 7
	ddr3_byte_ram u_ram_odd (
		.clk     (clk),
		.we      (odd_we),
		.wr_addr (wr_addr),
		.rd_addr (rd_addr),
		.wr_data (odd_byte),
		.rd_data (ram_odd_q)
	);

endmodule

`default_nettype wire

/* rtl/ddr3_proto_pkg.sv */
`default_nettype none

package ddr3_proto_pkg;

	// code is {cs_n, ras_n, cas_n, we_n}
	// precharge, refresh, mrs, zqc and deselect are not listed
	typedef enum logic [3:0] {
		cmd_activate = 4'b0011,
		cmd_write    = 4'b0100,
		cmd_read     = 4'b0101,
		cmd_nop      = 4'b0111
	} cmd_e;

	// AL, CL and CWL as programmed in the mode registers
	localparam int additive_latency = 3;
	localparam int cas_latency = 5;
	localparam int cas_write_latency = 5;

	// RL = AL + CL, WL = AL + CWL
	localparam int read_latency = additive_latency + cas_latency;
	localparam int write_latency = additive_latency + cas_write_latency;

	// fixed BL8, two beats per clock
	localparam int burst_beats = 8;
	localparam int burst_pairs = burst_beats / 2;

	// rising sample to registered beat pair
	localparam int capture_delay = 1;

	// tCCD, column command to column command
	localparam int min_cmd_gap = 4;

endpackage

`default_nettype wire

/* rtl/ddr3_read_burst.sv */
`default_nettype none

module ddr3_read_burst (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic start,
	input wire ddr3_geom_pkg::burst_addr_t start_addr,
	input wire ddr3_geom_pkg::byte_t even_byte,
	input wire ddr3_geom_pkg::byte_t odd_byte,
	output ddr3_geom_pkg::ram_addr_t rd_addr,
	output ddr3_geom_pkg::byte_t dq_out,
	output logic dq_oe,
	output logic dqs_en
);

	typedef enum logic {
		idle,
		burst
	} state_e;

	state_e state;
	logic [ddr3_geom_pkg::pair_w-1:0] pair;
	ddr3_geom_pkg::burst_addr_t held_addr;
	logic active;

	// address phase, pair 0 straight from start_addr
	assign active = start || (state == burst);
	assign rd_addr = (state == idle) ? {start_addr, {ddr3_geom_pkg::pair_w{1'b0}}}
		: {held_addr, pair};

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			state <= idle;
			pair <= '0;
		end
		else
		begin
			case (state)
				idle:
					if (start)
					begin
						state <= burst;
						pair <= 1'b1;
					end
				burst:
					// seamless read lands in the idle cycle right after pair 3
					if (pair == ddr3_proto_pkg::burst_pairs - 1)
					begin
						state <= idle;
						pair <= '0;
					end
					else
						pair <= pair + 1'b1;
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (state == idle && start)
			held_addr <= start_addr;
	end

	// ram output is one cycle behind its address
	always_ff @(posedge clk)
	begin
		if (!reset_n)
			dq_oe <= 1'b0;
		else
			dq_oe <= active;
	end

	// address cycle doubles as the strobe preamble
	assign dqs_en = active || dq_oe;

	// even beat in the high phase, odd beat in the low phase
	assign dq_out = clk ? even_byte : odd_byte;

	// read bursts never overlap, a seamless start follows pair 3
	a_rd_start: assert property (@(posedge clk) disable iff (!reset_n)
		start |-> state == idle);

endmodule

`default_nettype wire

/* rtl/ddr3_write_burst.sv */
`default_nettype none

module ddr3_write_burst (
	input wire logic clk,
	input wire logic reset_n,
	input wire logic start,
	input wire ddr3_geom_pkg::burst_addr_t start_addr,
	input wire logic even_mask,
	input wire logic odd_mask,
	output ddr3_geom_pkg::ram_addr_t wr_addr,
	output logic even_we,
	output logic odd_we
);

	typedef enum logic {
		idle,
		burst
	} state_e;

	state_e state;
	logic [ddr3_geom_pkg::pair_w-1:0] pair;
	ddr3_geom_pkg::burst_addr_t held_addr;
	logic active;

	// pair 0 is the start cycle, pairs 1..3 follow in burst
	assign active = start || (state == burst);
	assign wr_addr = (state == idle) ? {start_addr, {ddr3_geom_pkg::pair_w{1'b0}}}
		: {held_addr, pair};

	// dm high keeps the stored byte
	assign even_we = active && !even_mask;
	assign odd_we = active && !odd_mask;

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			state <= idle;
			pair <= '0;
		end
		else
		begin
			case (state)
				idle:
					if (start)
					begin
						state <= burst;
						pair <= 1'b1;
					end
				burst:
					// back to idle after pair 3, next start may follow at once
					if (pair == ddr3_proto_pkg::burst_pairs - 1)
					begin
						state <= idle;
						pair <= '0;
					end
					else
						pair <= pair + 1'b1;
				default: state <= idle;
			endcase
		end
	end

	// held for pairs 1..3
	always_ff @(posedge clk)
	begin
		if (state == idle && start)
			held_addr <= start_addr;
	end

	// write commands never overlap, a new burst only follows pair 3
	a_wr_start: assert property (@(posedge clk) disable iff (!reset_n)
		start |-> state == idle);

endmodule

`default_nettype wire

/* sources.f */
rtl/ddr3_geom_pkg.sv
rtl/ddr3_proto_pkg.sv
rtl/ddr3_cmd_decode.sv
rtl/ddr3_latency_line.sv
rtl/ddr3_ddr_capture.sv
rtl/ddr3_write_burst.sv
rtl/ddr3_read_burst.sv
rtl/ddr3_byte_ram.sv
rtl/ddr3_model_top.sv
testbench/tb_ddr3_model.sv

/* testbench/tb_ddr3_model.sv */
`default_nettype none

module tb_ddr3_model;
	timeunit 1ns;
	timeprecision 1ps;

	// commands per test, each one takes a 4 cycle slot or a little more
	localparam int n_idle = 8;
	localparam int n_basic = 3;
	localparam int n_mask = 2;
	localparam int n_bank = 11;
	localparam int n_seam = 2;
	localparam int n_rand = 300;
	localparam int cycle_limit = (n_idle + n_basic + n_mask + n_bank + n_seam + n_rand) * 8 + 200;
	localparam int sched_depth = 4096;

	logic clk;
	logic reset_n;
	logic cs_n;
	logic ras_n;
	logic cas_n;
	logic we_n;
	ddr3_geom_pkg::bank_t ba;
	ddr3_geom_pkg::pin_addr_t a;
	ddr3_geom_pkg::byte_t dq_in;
	logic dm;
	ddr3_geom_pkg::byte_t dq_out;
	logic dq_oe;
	logic dqs_en;

	integer seed;
	int cyc;
	int err_count;
	int check_count;
	int test_err_start;

	// reference model, indexed by {bank, row, column}
	logic [7:0] model_mem [0:65535];
	logic model_wr [0:65535];
	logic [5:0] model_row [0:7];
	// last write command cycle per {bank, row, group}
	int last_wr [0:8191];

	// write beats to drive, indexed by the rising edge that owns the pair
	logic drv_even_v [0:sched_depth-1];
	logic [7:0] drv_even_d [0:sched_depth-1];
	logic drv_even_m [0:sched_depth-1];
	logic drv_odd_v [0:sched_depth-1];
	logic [7:0] drv_odd_d [0:sched_depth-1];
	logic drv_odd_m [0:sched_depth-1];

	// expected outputs in the cycle after each rising edge
	logic exp_oe [0:sched_depth-1];
	logic exp_dqs [0:sched_depth-1];
	logic exp_even_f [0:sched_depth-1];
	logic [7:0] exp_even [0:sched_depth-1];
	logic exp_odd_f [0:sched_depth-1];
	logic [7:0] exp_odd [0:sched_depth-1];

	ddr3_model_top u_dut (
		.clk     (clk),
		.reset_n (reset_n),
		.cs_n    (cs_n),
		.ras_n   (ras_n),
		.cas_n   (cas_n),
		.we_n    (we_n),
		.ba      (ba),
		.a       (a),
		.dq_in   (dq_in),
		.dm      (dm),
		.dq_out  (dq_out),
		.dq_oe   (dq_oe),
		.dqs_en  (dqs_en)
	);

	always #10 clk = ~clk;

	// edge counter and run limit
	always @(posedge clk)
	begin
		cyc <= cyc + 1;
		if (cyc + 1 >= cycle_limit)
		begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// odd beat after the rising edge, next even beat after the falling edge
	always
	begin
		@(posedge clk);
		#1;
		dq_in = drv_odd_v[cyc] ? drv_odd_d[cyc] : 8'h00;
		dm = drv_odd_v[cyc] ? drv_odd_m[cyc] : 1'b0;
		@(negedge clk);
		#1;
		dq_in = drv_even_v[cyc+1] ? drv_even_d[cyc+1] : 8'h00;
		dm = drv_even_v[cyc+1] ? drv_even_m[cyc+1] : 1'b0;
	end

	// mid high phase, then mid low phase
	always
	begin
		@(posedge clk);
		#5;
		check_count = check_count + 2;
		if (dq_oe !== exp_oe[cyc])
		begin
			$display("error at %0t: dq_oe = %b, expected %b", $time, dq_oe, exp_oe[cyc]);
			err_count++;
		end
		if (dqs_en !== exp_dqs[cyc])
		begin
			$display("error at %0t: dqs_en = %b, expected %b", $time, dqs_en, exp_dqs[cyc]);
			err_count++;
		end
		if (exp_even_f[cyc])
		begin
			check_count++;
			if (dq_out !== exp_even[cyc])
			begin
				$display("error at %0t: dq_out = %h, expected %h", $time, dq_out, exp_even[cyc]);
				err_count++;
			end
		end
		#10;
		if (exp_odd_f[cyc])
		begin
			check_count++;
			if (dq_out !== exp_odd[cyc])
			begin
				$display("error at %0t: dq_out = %h, expected %h", $time, dq_out, exp_odd[cyc]);
				err_count++;
			end
		end
	end

	// one command slot, model updated at command time
	task automatic issue_cmd(input logic [3:0] code, input logic [2:0] bank,
		input logic [12:0] addr, input logic [63:0] data, input logic [7:0] mask);
		int t0;
		int base;
		int key;
		int slot;
		int i;
		key = {bank, model_row[bank], addr[6:3]};
		@(posedge clk);
		#1;
		// keep reads clear of a recent write to the same group
		while (code == ddr3_proto_pkg::cmd_read && cyc + 1 - last_wr[key] <= 8)
		begin
			@(posedge clk);
			#1;
		end
		{cs_n, ras_n, cas_n, we_n} = code;
		ba = bank;
		a = addr;
		t0 = cyc + 1;
		base = {bank, model_row[bank], addr[6:3], 3'b000};
		if (code == ddr3_proto_pkg::cmd_activate)
			model_row[bank] = addr[5:0];
		else if (code == ddr3_proto_pkg::cmd_write)
		begin
			last_wr[key] = t0;
			for (i = 0; i < 8; i++)
			begin
				if (!mask[i])
				begin
					model_mem[base+i] = data[8*i +: 8];
					model_wr[base+i] = 1'b1;
				end
			end
			// pair i sampled at edge t0+8+i and the falling edge after it
			for (i = 0; i < 4; i++)
			begin
				slot = t0 + 8 + i;
				drv_even_v[slot] = 1'b1;
				drv_even_d[slot] = data[16*i +: 8];
				drv_even_m[slot] = mask[2*i];
				drv_odd_v[slot] = 1'b1;
				drv_odd_d[slot] = data[16*i+8 +: 8];
				drv_odd_m[slot] = mask[2*i+1];
			end
		end
		else if (code == ddr3_proto_pkg::cmd_read)
		begin
			// one preamble cycle, then four data cycles
			for (i = 0; i < 5; i++)
				exp_dqs[t0+7+i] = 1'b1;
			for (i = 0; i < 4; i++)
			begin
				slot = t0 + 8 + i;
				exp_oe[slot] = 1'b1;
				exp_even[slot] = model_mem[base+2*i];
				exp_even_f[slot] = model_wr[base+2*i];
				exp_odd[slot] = model_mem[base+2*i+1];
				exp_odd_f[slot] = model_wr[base+2*i+1];
			end
		end
		@(posedge clk);
		#1;
		{cs_n, ras_n, cas_n, we_n} = ddr3_proto_pkg::cmd_nop;
		repeat (2) @(posedge clk);
	endtask

	// drain the read pipe, then report
	task automatic finish_test(input int num, input string name);
		repeat (16) @(posedge clk);
		$display("test %0d %s done, %0d errors", num, name, err_count - test_err_start);
		test_err_start = err_count;
	endtask

	initial
	begin
		int n;
		int kind;
		logic [2:0] bank;
		logic [12:0] addr;
		logic [63:0] data;
		logic [7:0] mask;
		logic [3:0] code;
		seed = 32'hd4a6;
		cyc = 0;
		err_count = 0;
		check_count = 0;
		test_err_start = 0;
		clk = 1'b0;
		reset_n = 1'b0;
		{cs_n, ras_n, cas_n, we_n} = 4'b1111;
		ba = '0;
		a = '0;
		dq_in = '0;
		dm = 1'b0;
		for (n = 0; n < sched_depth; n++)
		begin
			drv_even_v[n] = 1'b0;
			drv_odd_v[n] = 1'b0;
			exp_oe[n] = 1'b0;
			exp_dqs[n] = 1'b0;
			exp_even_f[n] = 1'b0;
			exp_odd_f[n] = 1'b0;
		end
		for (n = 0; n < 65536; n++)
			model_wr[n] = 1'b0;
		for (n = 0; n < 8192; n++)
			last_wr[n] = -1000;
		// open-row table comes out of reset at row 0
		for (n = 0; n < 8; n++)
			model_row[n] = '0;

		repeat (10) @(posedge clk);
		#1;
		reset_n = 1'b1;

		// nop, deselect, precharge and refresh start no output
		for (n = 0; n < n_idle; n++)
		begin
			case (n % 4)
				0: code = ddr3_proto_pkg::cmd_nop;
				1: code = 4'b1111;
				2: code = 4'b0010;
				default: code = 4'b0001;
			endcase
			issue_cmd(code, n[2:0], 13'h1fff, '0, '0);
		end
		finish_test(1, "idle outputs");

		// upper pins set on purpose, only the low bits select row and column
		data = {$random(seed), $random(seed)};
		issue_cmd(ddr3_proto_pkg::cmd_activate, 3'd1, 13'h0a45, '0, '0);
		issue_cmd(ddr3_proto_pkg::cmd_write, 3'd1, 13'h101d, data, 8'h00);
		issue_cmd(ddr3_proto_pkg::cmd_read, 3'd1, 13'h0018, '0, '0);
		finish_test(2, "write then read");

		data = {$random(seed), $random(seed)};
		issue_cmd(ddr3_proto_pkg::cmd_write, 3'd1, 13'h0019, data, 8'b1010_0101);
		issue_cmd(ddr3_proto_pkg::cmd_read, 3'd1, 13'h001f, '0, '0);
		finish_test(3, "data mask");

		// bank 2 row 7, bank 5 row 9, then bank 2 moved to row 8 and back
		issue_cmd(ddr3_proto_pkg::cmd_activate, 3'd2, 13'h0007, '0, '0);
		issue_cmd(ddr3_proto_pkg::cmd_activate, 3'd5, 13'h0009, '0, '0);
		issue_cmd(ddr3_proto_pkg::cmd_write, 3'd2, 13'h0008, {$random(seed), $random(seed)}, 8'h00);
		issue_cmd(ddr3_proto_pkg::cmd_write, 3'd5, 13'h000c, {$random(seed), $random(seed)}, 8'h00);
		issue_cmd(ddr3_proto_pkg::cmd_read, 3'd2, 13'h0008, '0, '0);
		issue_cmd(ddr3_proto_pkg::cmd_read, 3'd5, 13'h0008, '0, '0);
		issue_cmd(ddr3_proto_pkg::cmd_activate, 3'd2, 13'h0008, '0, '0);
		issue_cmd(ddr3_proto_pkg::cmd_write, 3'd2, 13'h0008, {$random(seed), $random(seed)}, 8'h00);
		issue_cmd(ddr3_proto_pkg::cmd_read, 3'd2, 13'h0008, '0, '0);
		issue_cmd(ddr3_proto_pkg::cmd_activate, 3'd2, 13'h0007, '0, '0);
		issue_cmd(ddr3_proto_pkg::cmd_read, 3'd2, 13'h0008, '0, '0);
		finish_test(4, "banks and rows");

		// back to back slots are exactly 4 cycles apart
		issue_cmd(ddr3_proto_pkg::cmd_read, 3'd1, 13'h0018, '0, '0);
		issue_cmd(ddr3_proto_pkg::cmd_read, 3'd5, 13'h0008, '0, '0);
		finish_test(5, "seamless reads");

		// rows 0..3 and groups 0..3 so that accesses hit each other
		for (n = 0; n < n_rand; n++)
		begin
			kind = $unsigned($random(seed)) % 5;
			bank = $random(seed);
			addr = $random(seed);
			data = {$random(seed), $random(seed)};
			mask = $random(seed);
			case (kind)
				0:
				begin
					addr[5:2] = 4'b0000;
					code = ddr3_proto_pkg::cmd_activate;
				end
				1:
				begin
					addr[6:5] = 2'b00;
					code = ddr3_proto_pkg::cmd_read;
				end
				2:
				begin
					addr[6:5] = 2'b00;
					code = ddr3_proto_pkg::cmd_write;
				end
				3: code = ddr3_proto_pkg::cmd_nop;
				default:
				begin
					code = $random(seed);
					// deselect instead of a decoded command
					if (code == ddr3_proto_pkg::cmd_activate || code == ddr3_proto_pkg::cmd_read
						|| code == ddr3_proto_pkg::cmd_write)
						code[3] = 1'b1;
				end
			endcase
			issue_cmd(code, bank, addr, data, mask);
		end
		finish_test(6, "random commands");

		$display("%0d checks, %0d errors", check_count, err_count);
		if (err_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
